/* hdl/cmd_codes_pkg.sv */
`default_nettype none

package cmd_codes_pkg;

  // upper nibble of the command byte
  typedef enum logic [3:0] {
    op_set_addr  = 4'h0,
    op_rom_mask  = 4'h1,
    op_sram_mask = 4'h2,
    op_read      = 4'h8,
    op_write     = 4'h9,
    op_ext       = 4'hE,
    op_info      = 4'hF
  } cmd_op_e;

  // full opcodes of the 0xE and 0xF groups
  typedef enum logic [7:0] {
    dac_pause   = 8'hE1,
    dac_resume  = 8'hE2,
    dac_props   = 8'hEC,
    feature_set = 8'hED,
    region_set  = 8'hEE,
    sig_read    = 8'hF0,
    status_read = 8'hF1,
    sysclk_read = 8'hFE,
    loopback    = 8'hFF
  } cmd_ext_e;

  // byte index in a frame, command byte is 1
  typedef logic [7:0] byte_cnt_t;

  localparam byte_cnt_t pos_cmd = 8'd1;
  localparam byte_cnt_t pos_p1  = 8'd2;
  localparam byte_cnt_t pos_p2  = 8'd3;
  localparam byte_cnt_t pos_p3  = 8'd4;
  localparam byte_cnt_t pos_p4  = 8'd5;

  // pointer select in the low command bits
  localparam logic [1:0] tgt_sram = 2'b00;
  localparam logic [1:0] tgt_dac  = 2'b01;
  localparam logic [1:0] tgt_msu  = 2'b10;

  localparam logic [7:0] sig_byte = 8'hA5;
  localparam int spi_sync_stages = 2;

endpackage

`default_nettype wire

/* hdl/cart_cfg_pkg.sv */
`default_nettype none

package cart_cfg_pkg;

  // dac playback settings, pointer lives in addr_ptrs_t
  typedef struct packed {
    logic       play;
    logic [2:0] vol_select;
    logic       palmode;
  } dac_cfg_t;

  typedef struct packed {
    logic [23:0] sram_addr;
    logic [10:0] dac_addr;
    logic [13:0] msu_addr;
  } addr_ptrs_t;

  typedef struct packed {
    logic [23:0] rom_mask;
    logic [23:0] saveram_mask;
  } masks_t;

  typedef struct packed {
    logic [7:0] featurebits;
    logic       region;
  } sys_cfg_t;

  // measurement window in clk cycles
  localparam int freq_gate_cycles = 1024;
  localparam int freq_gate_w = $clog2(freq_gate_cycles);

endpackage

`default_nettype wire

/* hdl/spi_byte_framer.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_framer import cmd_codes_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       ss_n,
  input  logic       mosi,
  output logic       miso,
  input  logic [7:0] reply_byte,
  output logic       cmd_ready,
  output logic       param_ready,
  output logic [7:0] cmd_data,
  output logic [7:0] param_data,
  output byte_cnt_t  byte_cnt
);

  logic [spi_sync_stages-1:0] sclk_sync;
  logic [spi_sync_stages-1:0] mosi_sync;
  logic [spi_sync_stages-1:0] ss_sync;
  logic       sclk_s;
  logic       mosi_s;
  logic       ss_s;
  logic       sclk_q;
  logic       sclk_rise;
  logic       sclk_fall;
  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [7:0] rx_byte;
  logic [7:0] tx_shift;
  logic       load_pend;

  assign sclk_s  = sclk_sync[spi_sync_stages-1];
  assign mosi_s  = mosi_sync[spi_sync_stages-1];
  assign ss_s    = ss_sync[spi_sync_stages-1];
  assign rx_byte = {rx_shift, mosi_s};
  assign miso    = tx_shift[7];

  ////////////////////
  // pin sync and edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync <= '0;
      mosi_sync <= '0;
      ss_sync   <= '1;
      sclk_q    <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end else begin
      sclk_sync <= {sclk_sync[spi_sync_stages-2:0], sclk};
      mosi_sync <= {mosi_sync[spi_sync_stages-2:0], mosi};
      ss_sync   <= {ss_sync[spi_sync_stages-2:0], ss_n};
      sclk_q    <= sclk_s;
      sclk_rise <= sclk_s & ~sclk_q;
      sclk_fall <= ~sclk_s & sclk_q;
    end
  end

  ////////////////////
  // byte framing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt     <= '0;
      byte_cnt    <= '0;
      cmd_ready   <= 1'b0;
      param_ready <= 1'b0;
      cmd_data    <= '0;
    end else begin
      cmd_ready   <= 1'b0;
      param_ready <= 1'b0;
      if (ss_s) begin
        bit_cnt  <= '0;
        byte_cnt <= '0;
      end else if (sclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          if (byte_cnt == '0) begin
            cmd_ready <= 1'b1;
            cmd_data  <= rx_byte;
          end else begin
            param_ready <= 1'b1;
          end
          // saturate on long frames
          if (byte_cnt != '1)
            byte_cnt <= byte_cnt + 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sclk_rise && !ss_s) begin
      rx_shift <= rx_byte[6:0];
      if (bit_cnt == 3'd7)
        param_data <= rx_byte;
    end
  end

  // reply shifted out msb first on falling sclk inside a byte
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_pend <= 1'b0;
      tx_shift  <= '0;
    end else begin
      load_pend <= cmd_ready | param_ready;
      if (load_pend)
        tx_shift <= reply_byte;
      else if (sclk_fall && bit_cnt != 3'd0)
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  // a frame ends on a byte boundary
  a_frame_whole: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ss_s) |-> bit_cnt == 3'd0);

endmodule

`default_nettype wire

/* hdl/sysclk_freq_meter.sv */
`timescale 1ns/1ps
`default_nettype none

module sysclk_freq_meter import cart_cfg_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        snes_sysclk,
  output logic [31:0] sysclk_freq,
  output logic        freq_valid
);

  // two sync flops plus one for the edge
  logic [2:0]             sys_sync;
  logic                   sys_rise;
  logic [freq_gate_w-1:0] gate_cnt;
  logic                   gate_end;
  logic [31:0]            edge_cnt;

  assign sys_rise = sys_sync[1] & ~sys_sync[2];
  assign gate_end = gate_cnt == freq_gate_w'(freq_gate_cycles - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sys_sync    <= '0;
      gate_cnt    <= '0;
      edge_cnt    <= '0;
      sysclk_freq <= '0;
      freq_valid  <= 1'b0;
    end else begin
      sys_sync <= {sys_sync[1:0], snes_sysclk};
      if (gate_end) begin
        gate_cnt    <= '0;
        // include an edge landing on the last cycle
        sysclk_freq <= edge_cnt + 32'(sys_rise);
        edge_cnt    <= '0;
        freq_valid  <= 1'b1;
      end else begin
        gate_cnt <= gate_cnt + 1'b1;
        edge_cnt <= edge_cnt + 32'(sys_rise);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/mcu_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module mcu_cmd import cmd_codes_pkg::*, cart_cfg_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_ready,
  input  logic        param_ready,
  input  logic [7:0]  cmd_data,
  input  logic [7:0]  param_data,
  input  byte_cnt_t   byte_cnt,
  output logic [7:0]  reply_byte,
  output logic        mcu_rrq,
  output logic        mcu_wrq,
  output logic        mcu_write,
  input  logic        mcu_rq_rdy,
  input  logic [7:0]  mcu_data_in,
  output logic [7:0]  mcu_data_out,
  output addr_ptrs_t  ptrs,
  output masks_t      masks,
  output dac_cfg_t    dac,
  output sys_cfg_t    sys,
  input  logic        dac_status,
  input  logic [6:0]  msu_status,
  input  logic [31:0] sysclk_freq
);

  typedef enum logic {rq_idle, rq_pulse} rq_state_e;

  cmd_op_e     op;
  cmd_ext_e    ext;
  rq_state_e   rrq_state;
  rq_state_e   wrq_state;
  logic [2:0]  rdy_sync;
  logic        mcu_nextaddr;
  logic        inc_en;
  logic        dac_status_q;
  logic [6:0]  msu_status_q;
  logic [31:0] freq_snap;

  function automatic logic [23:0] put_byte24(logic [23:0] cur, byte_cnt_t pos,
                                             logic [7:0] b);
    logic [23:0] v;
    v = cur;
    case (pos)
      pos_p1: v[23:16] = b;
      pos_p2: v[15:8] = b;
      pos_p3: v[7:0] = b;
      default: ;
    endcase
    return v;
  endfunction

  assign op  = cmd_op_e'(cmd_data[7:4]);
  assign ext = cmd_ext_e'(cmd_data);
  // second synced edge of the memory ready level
  assign mcu_nextaddr = rdy_sync[1] & ~rdy_sync[2];
  // writes start counting after their first data byte
  assign inc_en = mcu_nextaddr && cmd_data[7:5] == 3'b100 && cmd_data[3]
                  && byte_cnt >= pos_cmd + byte_cnt_t'(cmd_data[4]);
  assign mcu_rrq   = rrq_state == rq_pulse;
  assign mcu_wrq   = wrq_state == rq_pulse;
  assign mcu_write = 1'b1;

  ////////////////////
  // address pointers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptrs <= '0;
    end else if (param_ready && op == op_set_addr) begin
      case (cmd_data[1:0])
        tgt_dac:
          if (byte_cnt == pos_p1)
            ptrs.dac_addr <= {param_data[2:0], 8'h00};
          else if (byte_cnt == pos_p2)
            ptrs.dac_addr[7:0] <= param_data;
        tgt_msu:
          if (byte_cnt == pos_p1)
            ptrs.msu_addr <= {param_data[5:0], 8'h00};
          else if (byte_cnt == pos_p2)
            ptrs.msu_addr[7:0] <= param_data;
        default:
          // first byte clears the lower ones
          if (byte_cnt == pos_p1)
            ptrs.sram_addr <= {param_data, 16'h0000};
          else
            ptrs.sram_addr <= put_byte24(ptrs.sram_addr, byte_cnt, param_data);
      endcase
    end else if (inc_en) begin
      case (cmd_data[1:0])
        tgt_dac: ptrs.dac_addr <= ptrs.dac_addr + 11'd1;
        tgt_msu: ptrs.msu_addr <= ptrs.msu_addr + 14'd1;
        default: ptrs.sram_addr <= ptrs.sram_addr + 24'd1;
      endcase
    end
  end

  ////////////////////
  // configuration
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      masks <= '0;
      dac   <= '0;
      sys   <= '0;
    end else if (param_ready) begin
      case (op)
        op_rom_mask:  masks.rom_mask <= put_byte24(masks.rom_mask, byte_cnt, param_data);
        op_sram_mask: masks.saveram_mask <= put_byte24(masks.saveram_mask, byte_cnt,
                                                       param_data);
        op_ext:
          case (ext)
            dac_pause:  dac.play <= 1'b0;
            dac_resume: dac.play <= 1'b1;
            dac_props: begin
              dac.vol_select <= param_data[2:0];
              dac.palmode    <= param_data[7];
            end
            feature_set: sys.featurebits <= param_data;
            region_set:  sys.region <= param_data[0];
            default: ;
          endcase
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    dac_status_q <= dac_status;
    msu_status_q <= msu_status;
    if (param_ready && op == op_write)
      mcu_data_out <= param_data;
    // frequency snapshot on the command byte
    if (cmd_ready && ext == sysclk_read)
      freq_snap <= sysclk_freq;
  end

  ////////////////////
  // read-back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reply_byte <= '0;
    end else if (op == op_read && mcu_nextaddr) begin
      reply_byte <= mcu_data_in;
    end else if (cmd_ready || param_ready) begin
      case (ext)
        sig_read: reply_byte <= sig_byte;
        status_read:
          reply_byte <= byte_cnt[0] ? {1'b0, dac_status_q, msu_status_q[6], 5'b0}
                                    : {2'b00, msu_status_q[5:0]};
        sysclk_read:
          case (byte_cnt)
            pos_p1: reply_byte <= freq_snap[31:24];
            pos_p2: reply_byte <= freq_snap[23:16];
            pos_p3: reply_byte <= freq_snap[15:8];
            pos_p4: reply_byte <= freq_snap[7:0];
            default: ;
          endcase
        loopback: reply_byte <= param_data;
        default: ;
      endcase
    end
  end

  // one-cycle request pulsers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_sync  <= '0;
      rrq_state <= rq_idle;
      wrq_state <= rq_idle;
    end else begin
      rdy_sync <= {rdy_sync[1:0], mcu_rq_rdy};
      case (rrq_state)
        rq_idle:  if ((cmd_ready || param_ready) && op == op_read) rrq_state <= rq_pulse;
        rq_pulse: rrq_state <= rq_idle;
      endcase
      case (wrq_state)
        rq_idle:  if (param_ready && op == op_write) wrq_state <= rq_pulse;
        rq_pulse: wrq_state <= rq_idle;
      endcase
    end
  end

  // previous access must be complete before a new request
  a_rq_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    (mcu_rrq || mcu_wrq) |-> rdy_sync == 3'b000);

endmodule

`default_nettype wire

/* hdl/cart_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_cmd_top import cmd_codes_pkg::*, cart_cfg_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       ss_n,
  input  logic       mosi,
  output logic       miso,
  output logic       mcu_rrq,
  output logic       mcu_wrq,
  output logic       mcu_write,
  input  logic       mcu_rq_rdy,
  input  logic [7:0] mcu_data_in,
  output logic [7:0] mcu_data_out,
  output addr_ptrs_t ptrs,
  output masks_t     masks,
  output dac_cfg_t   dac,
  output sys_cfg_t   sys,
  input  logic       dac_status,
  input  logic [6:0] msu_status,
  input  logic       snes_sysclk,
  output logic       freq_valid
);

  logic        cmd_ready;
  logic        param_ready;
  logic [7:0]  cmd_data;
  logic [7:0]  param_data;
  byte_cnt_t   byte_cnt;
  logic [7:0]  reply_byte;
  logic [31:0] sysclk_freq;

  spi_byte_framer framer0 (
    .clk(clk), .rst_n(rst_n), .sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso),
    .reply_byte(reply_byte), .cmd_ready(cmd_ready), .param_ready(param_ready),
    .cmd_data(cmd_data), .param_data(param_data), .byte_cnt(byte_cnt)
  );

  mcu_cmd cmd0 (
    .clk(clk), .rst_n(rst_n), .cmd_ready(cmd_ready), .param_ready(param_ready),
    .cmd_data(cmd_data), .param_data(param_data), .byte_cnt(byte_cnt),
    .reply_byte(reply_byte), .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq),
    .mcu_write(mcu_write), .mcu_rq_rdy(mcu_rq_rdy), .mcu_data_in(mcu_data_in),
    .mcu_data_out(mcu_data_out), .ptrs(ptrs), .masks(masks), .dac(dac), .sys(sys),
    .dac_status(dac_status), .msu_status(msu_status), .sysclk_freq(sysclk_freq)
  );

  sysclk_freq_meter meter0 (
    .clk(clk), .rst_n(rst_n), .snes_sysclk(snes_sysclk),
    .sysclk_freq(sysclk_freq), .freq_valid(freq_valid)
  );

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* verification/cart_cmd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_cmd_tb import cmd_codes_pkg::*, cart_cfg_pkg::*; ();

  typedef enum logic [4:0] {
    k_sig, k_loop, k_ptr_sram, k_ptr_dac, k_ptr_msu, k_rom_mask, k_sram_mask,
    k_dac_props, k_feat, k_region, k_play, k_status, k_read, k_write, k_freq
  } chk_e;

  // frame bytes left aligned with the command byte in bits 63:56
  typedef struct packed {
    chk_e        kind;
    logic [3:0]  len;
    logic [63:0] frame;
    logic [31:0] exp_val;
  } step_t;

  localparam int byte_cycles = 64;
  localparam int frame_slack = 48;

  logic        clk;
  logic        rst_n;
  logic        sclk;
  logic        ss_n;
  logic        mosi;
  logic        miso;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic        mcu_write;
  logic        mcu_rq_rdy = 1'b0;
  logic [7:0]  mcu_data_in = 8'h00;
  logic [7:0]  mcu_data_out;
  addr_ptrs_t  ptrs;
  masks_t      masks;
  dac_cfg_t    dac;
  sys_cfg_t    sys;
  logic        dac_status;
  logic [6:0]  msu_status;
  logic        snes_sysclk = 1'b0;
  logic        freq_valid;

  step_t       steps[$];
  string       names[$];
  logic [7:0]  tx_buf[8];
  logic [7:0]  rx_buf[8];
  logic [7:0]  mem[256];
  logic [23:0] wr_addr_q[$];
  logic [7:0]  wr_data_q[$];
  logic        rq_seen;
  logic        wr_seen;
  logic [23:0] req_addr;
  logic [7:0]  req_data;
  logic [3:0]  rdy_cnt = 4'd0;
  logic [2:0]  sys_div = 3'd0;
  int          cycles = 0;
  int          cycle_limit = 0;

  tb_clk_gen clk_gen0 (.clk(clk), .rst_n(rst_n));

  cart_cmd_top dut0 (
    .clk(clk), .rst_n(rst_n), .sclk(sclk), .ss_n(ss_n), .mosi(mosi), .miso(miso),
    .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_write(mcu_write),
    .mcu_rq_rdy(mcu_rq_rdy), .mcu_data_in(mcu_data_in), .mcu_data_out(mcu_data_out),
    .ptrs(ptrs), .masks(masks), .dac(dac), .sys(sys), .dac_status(dac_status),
    .msu_status(msu_status), .snes_sysclk(snes_sysclk), .freq_valid(freq_valid)
  );

  ////////////////////
  // helpers
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // model data mixes in the upper address bytes
  function automatic logic [7:0] mem_read(logic [23:0] a);
    return mem[a[7:0]] ^ a[23:16] ^ a[15:8];
  endfunction

  task automatic fill_mem();
    logic [15:0] s;
    s = 16'd50765;
    for (int i = 0; i < 256; i++) begin
      for (int b = 0; b < 8; b++) begin
        mem[i][b] = s[0];
        s = lfsr_next(s);
      end
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act);
    if (act !== exp_val) begin
      $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp_val, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic add_step(input string name, input chk_e kind, input int len,
                          input logic [63:0] frame, input logic [31:0] exp_val);
    step_t s;
    s.kind    = kind;
    s.len     = 4'(len);
    s.frame   = frame;
    s.exp_val = exp_val;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic build_table();
    add_step("signature",   k_sig,       3, 64'hF000_0000_0000_0000, 32'h0);
    add_step("loopback",    k_loop,      5, 64'hFF3C_C35A_A500_0000, 32'h0);
    add_step("sram_ptr",    k_ptr_sram,  4, 64'h0012_3456_0000_0000, 32'h123456);
    add_step("sram_ptr_hi", k_ptr_sram,  2, 64'h0077_0000_0000_0000, 32'h770000);
    add_step("dac_ptr",     k_ptr_dac,   3, 64'h0105_3300_0000_0000, 32'h533);
    add_step("msu_ptr",     k_ptr_msu,   3, 64'h022A_7C00_0000_0000, 32'h2A7C);
    add_step("rom_mask",    k_rom_mask,  4, 64'h100F_FFFF_0000_0000, 32'h0FFFFF);
    add_step("sram_mask",   k_sram_mask, 4, 64'h2000_1FFF_0000_0000, 32'h001FFF);
    // palmode in bit 7 and volume in the low bits
    add_step("dac_props",   k_dac_props, 2, 64'hEC85_0000_0000_0000, 32'hD);
    add_step("features",    k_feat,      2, 64'hED5A_0000_0000_0000, 32'h5A);
    add_step("region",      k_region,    2, 64'hEE01_0000_0000_0000, 32'h1);
    add_step("dac_resume",  k_play,      2, 64'hE200_0000_0000_0000, 32'h1);
    add_step("dac_pause",   k_play,      2, 64'hE100_0000_0000_0000, 32'h0);
    // expected field is {dac_status, msu_status}
    add_step("status_a",    k_status,    3, 64'hF100_0000_0000_0000, 32'hD5);
    add_step("status_b",    k_status,    3, 64'hF100_0000_0000_0000, 32'h4B);
    add_step("read_ptr",    k_ptr_sram,  4, 64'h0000_01FE_0000_0000, 32'h0001FE);
    add_step("read_inc",    k_read,      6, 64'h8800_0000_0000_0000, 32'h0001FE);
    add_step("write_ptr",   k_ptr_sram,  4, 64'h0002_0040_0000_0000, 32'h020040);
    add_step("write_inc",   k_write,     4, 64'h9811_2233_0000_0000, 32'h020040);
    add_step("sysclk_freq", k_freq,      6, 64'hFE00_0000_0000_0000, 32'h0);
  endtask

  ////////////////////
  // mode 0 SPI master with a half sclk period of 4 clk
  task automatic spi_frame(input int len);
    @(posedge clk);
    ss_n <= 1'b0;
    repeat (4) @(posedge clk);
    for (int i = 0; i < len; i++) begin
      for (int b = 7; b >= 0; b--) begin
        mosi <= tx_buf[i][b];
        repeat (4) @(posedge clk);
        sclk <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rx_buf[i][b] = miso;
        repeat (2) @(posedge clk);
        sclk <= 1'b0;
      end
    end
    // room for the last memory access
    repeat (24) @(posedge clk);
    ss_n <= 1'b1;
    repeat (8) @(posedge clk);
  endtask

  task automatic run_step(input int n);
    step_t       s;
    string       nm;
    int          len;
    int          wr_base;
    logic [31:0] word;
    logic [31:0] nominal;
    s   = steps[n];
    nm  = names[n];
    len = int'(s.len);
    for (int i = 0; i < 8; i++)
      tx_buf[i] = s.frame[63-8*i -: 8];
    if (s.kind == k_status) begin
      @(posedge clk);
      dac_status <= s.exp_val[7];
      msu_status <= s.exp_val[6:0];
    end
    if (s.kind == k_freq) begin
      while (!freq_valid)
        @(posedge clk);
    end
    wr_base = wr_addr_q.size();
    spi_frame(len);
    case (s.kind)
      k_sig:       check_val({nm, "/reply"}, 32'(sig_byte), 32'(rx_buf[1]));
      k_loop:
        for (int i = 1; i < len; i++)
          check_val($sformatf("%s/byte%0d", nm, i), 32'(tx_buf[i-1]), 32'(rx_buf[i]));
      k_ptr_sram:  check_val(nm, s.exp_val, 32'(ptrs.sram_addr));
      k_ptr_dac:   check_val(nm, s.exp_val, 32'(ptrs.dac_addr));
      k_ptr_msu:   check_val(nm, s.exp_val, 32'(ptrs.msu_addr));
      k_rom_mask:  check_val(nm, s.exp_val, 32'(masks.rom_mask));
      k_sram_mask: check_val(nm, s.exp_val, 32'(masks.saveram_mask));
      k_dac_props: check_val(nm, s.exp_val, 32'({dac.palmode, dac.vol_select}));
      k_feat:      check_val(nm, s.exp_val, 32'(sys.featurebits));
      k_region:    check_val(nm, s.exp_val, 32'(sys.region));
      k_play:      check_val(nm, s.exp_val, 32'(dac.play));
      k_status: begin
        check_val({nm, "/first"}, 32'({1'b0, s.exp_val[7:6], 5'b00000}), 32'(rx_buf[1]));
        check_val({nm, "/second"}, 32'({2'b00, s.exp_val[5:0]}), 32'(rx_buf[2]));
      end
      k_read: begin
        // data of the access started in byte k shows up in byte k+2
        for (int i = 2; i < len; i++)
          check_val($sformatf("%s/byte%0d", nm, i),
                    32'(mem_read(s.exp_val[23:0] + 24'(i - 2))), 32'(rx_buf[i]));
        check_val({nm, "/ptr"}, s.exp_val + 32'(len), 32'(ptrs.sram_addr));
      end
      k_write: begin
        check_val({nm, "/count"}, 32'(len - 1), 32'(wr_addr_q.size() - wr_base));
        for (int i = 1; i < len; i++) begin
          check_val($sformatf("%s/addr%0d", nm, i), s.exp_val + 32'(i - 1),
                    32'(wr_addr_q[wr_base+i-1]));
          check_val($sformatf("%s/data%0d", nm, i), 32'(tx_buf[i]),
                    32'(wr_data_q[wr_base+i-1]));
        end
        check_val({nm, "/ptr"}, s.exp_val + 32'(len - 1), 32'(ptrs.sram_addr));
        check_val({nm, "/rw_level"}, 32'd1, 32'(mcu_write));
      end
      k_freq: begin
        word    = {rx_buf[2], rx_buf[3], rx_buf[4], rx_buf[5]};
        nominal = 32'(freq_gate_cycles / 5);
        // sync alignment can gain or lose one edge
        if (word + 32'd1 < nominal)
          check_val({nm, "/min"}, nominal - 32'd1, word);
        if (word > nominal + 32'd1)
          check_val({nm, "/max"}, nominal + 32'd1, word);
      end
    endcase
  endtask

  ////////////////////
  // memory model samples requests mid-cycle
  always @(negedge clk) begin
    rq_seen  <= mcu_rrq | mcu_wrq;
    wr_seen  <= mcu_wrq;
    req_addr <= ptrs.sram_addr;
    req_data <= mcu_data_out;
  end

  always @(posedge clk) begin
    if (rq_seen === 1'b1) begin
      if (wr_seen) begin
        wr_addr_q.push_back(req_addr);
        wr_data_q.push_back(req_data);
      end else begin
        mcu_data_in <= mem_read(req_addr);
      end
      rdy_cnt <= 4'd1;
    end else if (rdy_cnt != 4'd0) begin
      mcu_rq_rdy <= rdy_cnt >= 4'd3 && rdy_cnt <= 4'd6;
      rdy_cnt    <= (rdy_cnt == 4'd8) ? 4'd0 : rdy_cnt + 4'd1;
    end
  end

  // console clock with a 5 clk period
  always @(posedge clk) begin
    sys_div     <= (sys_div == 3'd4) ? 3'd0 : sys_div + 3'd1;
    snes_sysclk <= sys_div < 3'd2;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "timeout");
    end
  end

  initial begin
    sclk       = 1'b0;
    ss_n       = 1'b1;
    mosi       = 1'b0;
    dac_status = 1'b0;
    msu_status = 7'd0;
    fill_mem();
    build_table();
    cycle_limit = 8 + 2 * freq_gate_cycles + 200;
    foreach (steps[i])
      cycle_limit += int'(steps[i].len) * byte_cycles + frame_slack;
    wait (rst_n === 1'b1);
    repeat (4) @(posedge clk);
    for (int n = 0; n < steps.size(); n++)
      run_step(n);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hdl/cmd_codes_pkg.sv
hdl/cart_cfg_pkg.sv
hdl/spi_byte_framer.sv
hdl/sysclk_freq_meter.sv
hdl/mcu_cmd.sv
hdl/cart_cmd_top.sv
verification/tb_clk_gen.sv
verification/cart_cmd_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := cart_cmd_tb
FILELIST  := tb.f
FLAGS     := --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
